// File: sim.f
+incdir+.
rfPkg.sv
resultBusIf.sv
checkpointCtrl.sv
regLine.sv
operandRead.sv
regFile.sv
tbClock.sv
regFile_props.sv
regFileTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module regFileTb -f sim.f -o regFileSim
	./obj_dir/regFileSim > sim.log 2>&1 ; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: regFileTb.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module regFileTb import rfPkg::*; ();

  localparam int REGS          = `RF_REG_COUNT;
  localparam int SLOTS         = `RF_CKPT_DEPTH;
  localparam int RANDOM_CYCLES = 3000;
  localparam int RESET_LIMIT   = 20;

  logic    clk;
  logic    rst;
  logic    aluEn;
  tagT     aluTag;
  dataT    aluData;
  logic    lsEn;
  tagT     lsTag;
  dataT    lsData;
  logic    renameEn;
  regNameT renameName;
  tagT     renameTag;
  logic    branchDeeper;
  logic    branchFree;
  logic    misTaken;
  regNameT readNameA;
  regNameT readNameB;
  dataT    readDataA;
  tagT     readTagA;
  dataT    readDataB;
  tagT     readTagB;

  // reference model of every slot of every register plus the ring pointers.
  dataT    mData [REGS][SLOTS];
  tagT     mTag  [REGS][SLOTS];
  slotIdxT mHead;
  slotIdxT mTail;

  logic [31:0] rngState;
  logic        failShown = 1'b0;
  logic        runPassed = 1'b0;

  tbClock clkGen (.clk(clk), .rst(rst));

  regFile i_regFile (
    .clk(clk), .rst(rst),
    .aluEn(aluEn), .aluTag(aluTag), .aluData(aluData),
    .lsEn(lsEn), .lsTag(lsTag), .lsData(lsData),
    .renameEn(renameEn), .renameName(renameName), .renameTag(renameTag),
    .branchDeeper(branchDeeper), .branchFree(branchFree), .misTaken(misTaken),
    .readNameA(readNameA), .readNameB(readNameB),
    .readDataA(readDataA), .readTagA(readTagA),
    .readDataB(readDataB), .readTagB(readTagB)
  );

  // lcg step with the halves swapped so the weak low bits end up on top.
  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return {rngState[15:0], rngState[31:16]};
  endfunction

  task automatic stopWithFailure(input string msg);
    $display("[FAIL] t=%0t %s", $time, msg);
    failShown = 1'b1;
    $display("Finished with errors");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic compareData(input string what, input regNameT name,
                             input dataT expVal, input dataT actVal);
    if (actVal !== expVal) begin
      stopWithFailure($sformatf("%s r%0d data expected %h got %h",
                                what, name, expVal, actVal));
    end
  endtask

  task automatic compareTag(input string what, input regNameT name,
                            input tagT expVal, input tagT actVal);
    if (actVal !== expVal) begin
      stopWithFailure($sformatf("%s r%0d tag expected %0d got %0d",
                                what, name, expVal, actVal));
    end
  endtask

  // a pending slot with a matching bus tag turns final and the alu bus goes first.
  task automatic snoopSlot(input dataT d, input tagT t, output dataT od, output tagT ot);
    od = d;
    ot = t;
    if (t != TAG_FREE && aluEn && aluTag == t) begin
      od = aluData;
      ot = TAG_FREE;
    end else if (t != TAG_FREE && lsEn && lsTag == t) begin
      od = lsData;
      ot = TAG_FREE;
    end
  endtask

  task automatic expectRead(input regNameT name, output dataT d, output tagT t);
    if (name == '0) begin
      d = '0;
      t = TAG_FREE;
    end else begin
      snoopSlot(mData[name][mTail], mTag[name][mTail], d, t);
    end
  endtask

  task automatic checkReads();
    dataT expD;
    tagT  expT;
    expectRead(readNameA, expD, expT);
    compareData("port A", readNameA, expD, readDataA);
    compareTag("port A", readNameA, expT, readTagA);
    expectRead(readNameB, expD, expT);
    compareData("port B", readNameB, expD, readDataB);
    compareTag("port B", readNameB, expT, readTagB);
  endtask

  // clock edge of the model with the inputs of this cycle.
  task automatic advanceModel();
    dataT    nd [SLOTS];
    tagT     nt [SLOTS];
    slotIdxT nxt;
    nxt = mTail + slotIdxT'(1);
    for (int r = 0; r < REGS; r++) begin
      for (int s = 0; s < SLOTS; s++) begin
        snoopSlot(mData[r][s], mTag[r][s], nd[s], nt[s]);
      end
      if (branchDeeper && !misTaken) begin
        nd[nxt] = nd[mTail];
        nt[nxt] = nt[mTail];
      end
      if (renameEn && r != 0 && renameName == regNameT'(r)) begin
        nt[mTail] = renameTag;
      end
      for (int s = 0; s < SLOTS; s++) begin
        mData[r][s] = nd[s];
        mTag[r][s]  = nt[s];
      end
    end
    if (misTaken) begin
      mTail = mHead;
    end else begin
      if (branchFree) mHead = mHead + slotIdxT'(1);
      if (branchDeeper) mTail = nxt;
    end
  endtask

  task automatic idleInputs();
    aluEn        = 1'b0;
    aluTag       = TAG_FREE;
    aluData      = '0;
    lsEn         = 1'b0;
    lsTag        = TAG_FREE;
    lsData       = '0;
    renameEn     = 1'b0;
    renameName   = '0;
    renameTag    = TAG_FREE;
    branchDeeper = 1'b0;
    branchFree   = 1'b0;
    misTaken     = 1'b0;
    readNameA    = '0;
    readNameB    = '0;
  endtask

  task automatic beginCycle();
    @(posedge clk);
    #2;
    idleInputs();
  endtask

  task automatic endCycle();
    @(negedge clk);  // outputs settled mid cycle.
    checkReads();
    advanceModel();
  endtask

  task automatic waitForReset();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (rst && waited < RESET_LIMIT);
    if (rst) begin
      $display("timeout: reset never released within %0d cycles", RESET_LIMIT);
      failShown = 1'b1;
      $display("Finished with errors");
      $fatal(1, "reset timeout");
    end
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    slotIdxT     inFlight;
    inFlight = mTail - mHead;
    beginCycle();
    r = nextRand();
    misTaken = (r[3:0] == 4'd0);
    // keep at most three checkpoints and never rename beside a branch.
    if (r[6:4] < 3'd2 && inFlight < slotIdxT'(3)) branchDeeper = 1'b1;
    else renameEn = r[7] | r[8];
    branchFree = (r[11:9] < 3'd2) && (inFlight != '0);
    renameName = regNameT'(nextRand());
    renameTag  = tagT'(nextRand());
    if (renameTag == TAG_FREE) renameTag = tagT'(1);
    aluEn     = r[12];
    aluTag    = tagT'(nextRand());
    aluData   = nextRand();
    lsEn      = r[13];
    lsTag     = tagT'(nextRand());
    lsData    = nextRand();
    readNameA = regNameT'(nextRand());
    readNameB = regNameT'(nextRand());
    endCycle();
  endtask

  initial begin
    rngState = 32'hbc2ecf1d;
    idleInputs();
    // real lines on the read ports for the first cycle out of reset.
    readNameA = regNameT'(1);
    readNameB = regNameT'(REGS - 1);
    for (int r = 0; r < REGS; r++) begin
      for (int s = 0; s < SLOTS; s++) begin
        mData[r][s] = '0;
        mTag[r][s]  = TAG_FREE;
      end
    end
    mHead = '0;
    mTail = '0;
    waitForReset();

    // every register reads zero and free after reset.
    for (int n = 0; n < REGS; n++) begin
      beginCycle();
      readNameA = regNameT'(n);
      readNameB = regNameT'(REGS - 1 - n);
      endCycle();
      compareData("reset A", readNameA, '0, readDataA);
      compareTag("reset A", readNameA, TAG_FREE, readTagA);
      compareData("reset B", readNameB, '0, readDataB);
      compareTag("reset B", readNameB, TAG_FREE, readTagB);
    end

    // rename and then put the tag on both buses.
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(5);
    renameTag  = tagT'(3);
    readNameA  = regNameT'(5);
    endCycle();
    beginCycle();
    readNameA = regNameT'(5);
    endCycle();
    compareTag("renamed", regNameT'(5), tagT'(3), readTagA);
    beginCycle();
    aluEn     = 1'b1;
    aluTag    = tagT'(3);
    aluData   = 32'h1234_5678;
    lsEn      = 1'b1;
    lsTag     = tagT'(3);
    lsData    = 32'hdead_0001;
    readNameA = regNameT'(5);
    endCycle();
    compareData("alu wins", regNameT'(5), 32'h1234_5678, readDataA);
    compareTag("alu wins", regNameT'(5), TAG_FREE, readTagA);

    // one tag in two registers and two slots.
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(6);
    renameTag  = tagT'(7);
    readNameA  = regNameT'(5);
    endCycle();
    compareData("stored", regNameT'(5), 32'h1234_5678, readDataA);
    compareTag("stored", regNameT'(5), TAG_FREE, readTagA);
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(7);
    renameTag  = tagT'(7);
    endCycle();
    beginCycle();
    branchDeeper = 1'b1;
    readNameA    = regNameT'(6);
    readNameB    = regNameT'(7);
    endCycle();
    beginCycle();
    lsEn      = 1'b1;
    lsTag     = tagT'(7);
    lsData    = 32'h0bad_cafe;
    readNameA = regNameT'(6);
    readNameB = regNameT'(7);
    endCycle();
    compareData("shared tag", regNameT'(6), 32'h0bad_cafe, readDataA);
    compareData("shared tag", regNameT'(7), 32'h0bad_cafe, readDataB);
    // the older slot took the same result.
    beginCycle();
    misTaken = 1'b1;
    endCycle();
    beginCycle();
    readNameA = regNameT'(6);
    readNameB = regNameT'(7);
    endCycle();
    compareData("older slot", regNameT'(6), 32'h0bad_cafe, readDataA);
    compareTag("older slot", regNameT'(6), TAG_FREE, readTagA);
    compareData("older slot", regNameT'(7), 32'h0bad_cafe, readDataB);
    compareTag("older slot", regNameT'(7), TAG_FREE, readTagB);

    // mispredict keeps results that landed in the oldest slot.
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(9);
    renameTag  = tagT'(4);
    endCycle();
    beginCycle();
    branchDeeper = 1'b1;
    endCycle();
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(9);
    renameTag  = tagT'(9);
    endCycle();
    beginCycle();
    aluEn     = 1'b1;
    aluTag    = tagT'(4);
    aluData   = 32'h0000_4444;
    readNameA = regNameT'(9);
    endCycle();
    compareTag("younger rename", regNameT'(9), tagT'(9), readTagA);
    beginCycle();
    misTaken = 1'b1;
    endCycle();
    beginCycle();
    readNameA = regNameT'(9);
    endCycle();
    compareData("rollback", regNameT'(9), 32'h0000_4444, readDataA);

    // a released checkpoint is where a mispredict lands.
    beginCycle();
    branchDeeper = 1'b1;
    endCycle();
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(8);
    renameTag  = tagT'(5);
    endCycle();
    beginCycle();
    branchDeeper = 1'b1;
    endCycle();
    beginCycle();
    renameEn   = 1'b1;
    renameName = regNameT'(8);
    renameTag  = tagT'(6);
    endCycle();
    beginCycle();
    branchFree = 1'b1;
    endCycle();
    beginCycle();
    misTaken = 1'b1;
    endCycle();
    beginCycle();
    readNameA = regNameT'(8);
    endCycle();
    compareTag("released point", regNameT'(8), tagT'(5), readTagA);

    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      randomCycle();
    end

    runPassed = 1'b1;
    $display("Finished with no errors");
    $finish;
  end

  final begin
    if (!runPassed && !failShown) begin
      $display("Finished with errors");
    end
  end

endmodule

`default_nettype wire

// File: regFile_props.sv
`timescale 1ns/10ps
`default_nettype none

module regFileProps import rfPkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    renameEn,
  input logic    branchDeeper,
  input regNameT readNameA,
  input regNameT readNameB,
  input dataT    readDataA,
  input tagT     readTagA,
  input dataT    readDataB,
  input tagT     readTagB
);

  // the dispatcher never renames while a checkpoint is taken.
  noRenameOnBranch: assert property (@(posedge clk) disable iff (rst)
    !(renameEn && branchDeeper))
    else $error("rename and branch checkpoint in the same cycle");

  zeroRegA: assert property (@(posedge clk)
    (readNameA == '0) |-> (readDataA == '0 && readTagA == TAG_FREE))
    else $error("r0 on port A is not zero with a free tag");

  zeroRegB: assert property (@(posedge clk)
    (readNameB == '0) |-> (readDataB == '0 && readTagB == TAG_FREE))
    else $error("r0 on port B is not zero with a free tag");

  // nothing is renamed yet in the first cycle out of reset.
  freeAfterReset: assert property (@(posedge clk)
    $fell(rst) |-> (readTagA == TAG_FREE && readTagB == TAG_FREE))
    else $error("pending tag read right after reset");

endmodule

bind regFile regFileProps props (
  .clk          (clk),
  .rst          (rst),
  .renameEn     (renameEn),
  .branchDeeper (branchDeeper),
  .readNameA    (readNameA),
  .readNameB    (readNameB),
  .readDataA    (readDataA),
  .readTagA     (readTagA),
  .readDataB    (readDataB),
  .readTagB     (readTagB)
);

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock import rfPkg::*; (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 10;  // 20 ns clock.
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;  // released right after the third edge.
  end

endmodule

`default_nettype wire

// File: regFile.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module regFile import rfPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    aluEn,        // alu/rob result bus.
  input  tagT     aluTag,
  input  dataT    aluData,
  input  logic    lsEn,         // load/store result bus.
  input  tagT     lsTag,
  input  dataT    lsData,
  input  logic    renameEn,     // from the dispatcher.
  input  regNameT renameName,
  input  tagT     renameTag,
  input  logic    branchDeeper,
  input  logic    branchFree,
  input  logic    misTaken,
  input  regNameT readNameA,
  input  regNameT readNameB,
  output dataT    readDataA,
  output tagT     readTagA,
  output dataT    readDataB,
  output tagT     readTagB
);

  slotIdxT                  tail;
  slotIdxT                  nxtTail;
  logic                     ckptCopy;
  logic [`RF_REG_COUNT-1:0] renameOneHot;
  dataT                     lineData [`RF_REG_COUNT];
  tagT                      lineTag  [`RF_REG_COUNT];

  resultBusIf resBus ();

  assign resBus.aluEn   = aluEn;
  assign resBus.aluTag  = aluTag;
  assign resBus.aluData = aluData;
  assign resBus.lsEn    = lsEn;
  assign resBus.lsTag   = lsTag;
  assign resBus.lsData  = lsData;

  checkpointCtrl ctrl (
    .clk          (clk),
    .rst          (rst),
    .branchDeeper (branchDeeper),
    .branchFree   (branchFree),
    .misTaken     (misTaken),
    .renameEn     (renameEn),
    .renameName   (renameName),
    .tail         (tail),
    .nxtTail      (nxtTail),
    .ckptCopy     (ckptCopy),
    .renameOneHot (renameOneHot)
  );

  // one line per architectural register, all share the ring pointers.
  for (genvar g = 0; g < `RF_REG_COUNT; g++) begin : genLine
    regLine line (
      .clk       (clk),
      .rst       (rst),
      .rename    (renameOneHot[g]),
      .renameTag (renameTag),
      .tail      (tail),
      .nxtTail   (nxtTail),
      .ckptCopy  (ckptCopy),
      .res       (resBus.snoop),
      .curData   (lineData[g]),
      .curTag    (lineTag[g])
    );
  end

  operandRead rdStage (
    .nameA    (readNameA),
    .nameB    (readNameB),
    .lineData (lineData),
    .lineTag  (lineTag),
    .dataA    (readDataA),
    .tagA     (readTagA),
    .dataB    (readDataB),
    .tagB     (readTagB)
  );

endmodule

`default_nettype wire

// File: operandRead.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module operandRead import rfPkg::*; (
  input  regNameT nameA,
  input  regNameT nameB,
  input  dataT    lineData [`RF_REG_COUNT],
  input  tagT     lineTag  [`RF_REG_COUNT],
  output dataT    dataA,
  output tagT     tagA,
  output dataT    dataB,
  output tagT     tagB
);

  // first operand.
  always_comb begin
    if (nameA == '0) begin
      dataA = '0;  // r0 is constant zero.
      tagA  = TAG_FREE;
    end else begin
      dataA = lineData[nameA];
      tagA  = lineTag[nameA];
    end
  end

  // second operand, same rule.
  always_comb begin
    if (nameB == '0) begin
      dataB = '0;
      tagB  = TAG_FREE;
    end else begin
      dataB = lineData[nameB];
      tagB  = lineTag[nameB];
    end
  end

endmodule

`default_nettype wire

// File: regLine.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module regLine import rfPkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               rename,
  input  tagT                renameTag,
  input  slotIdxT            tail,
  input  slotIdxT            nxtTail,
  input  logic               ckptCopy,
  resultBusIf.snoop          res,
  output dataT               curData,
  output tagT                curTag
);

  localparam int DEPTH = `RF_CKPT_DEPTH;

  // stored checkpoint slots.
  dataT slotData [DEPTH];
  tagT  slotTag  [DEPTH];

  // slot contents after this cycle's results are applied.
  dataT snpData [DEPTH];
  tagT  snpTag  [DEPTH];

  // a pending slot takes a matching result and becomes final.
  // when both buses match, the alu bus wins.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      snpData[i] = slotData[i];
      snpTag[i]  = slotTag[i];
      if (slotTag[i] != TAG_FREE) begin
        if (res.aluEn && (res.aluTag == slotTag[i])) begin
          snpData[i] = res.aluData;
          snpTag[i]  = TAG_FREE;
        end else if (res.lsEn && (res.lsTag == slotTag[i])) begin
          snpData[i] = res.lsData;
          snpTag[i]  = TAG_FREE;
        end
      end
    end
  end

  // reads see the current slot with the bypass applied.
  assign curData = snpData[tail];
  assign curTag  = snpTag[tail];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        slotData[i] <= '0;
        slotTag[i]  <= TAG_FREE;
      end
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        slotData[i] <= snpData[i];
        if (rename && (slotIdxT'(i) == tail)) begin
          slotTag[i] <= renameTag;  // new producer for this register.
        end else begin
          slotTag[i] <= snpTag[i];
        end
      end
      // a branch opens a new slot from the current one.
      // never in the same cycle as a rename.
      if (ckptCopy) begin
        slotData[nxtTail] <= snpData[tail];
        slotTag[nxtTail]  <= snpTag[tail];
      end
    end
  end

endmodule

`default_nettype wire

// File: checkpointCtrl.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

module checkpointCtrl import rfPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     branchDeeper,
  input  logic                     branchFree,
  input  logic                     misTaken,
  input  logic                     renameEn,
  input  regNameT                  renameName,
  output slotIdxT                  tail,
  output slotIdxT                  nxtTail,
  output logic                     ckptCopy,
  output logic [`RF_REG_COUNT-1:0] renameOneHot
);

  // head is the oldest checkpoint, the last state known to be safe.
  slotIdxT head;
  slotIdxT nxtHead;

  // advance one position around the ring.
  function automatic slotIdxT ringNext(input slotIdxT idx);
    ringNext = (idx == slotIdxT'(`RF_CKPT_DEPTH - 1)) ? '0 : idx + slotIdxT'(1);
  endfunction

  assign nxtHead = ringNext(head);
  assign nxtTail = ringNext(tail);

  assign ckptCopy = branchDeeper & ~misTaken;  // a flush cancels the new checkpoint.

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else if (misTaken) begin
      tail <= head;  // roll back to the oldest checkpoint.
    end else begin
      if (branchFree) begin
        head <= nxtHead;  // oldest branch resolved.
      end
      if (branchDeeper) begin
        tail <= nxtTail;
      end
    end
  end

  // one enable per line, r0 stays out.
  always_comb begin
    renameOneHot = '0;
    renameOneHot[renameName] = renameEn;
    renameOneHot[0] = 1'b0;
  end

endmodule

`default_nettype wire

// File: resultBusIf.sv
`include "regFile_settings.svh"
`timescale 1ns/10ps
`default_nettype none

interface resultBusIf import rfPkg::*; ();

  // result from the alu side, routed through the rob.
  logic aluEn;
  tagT  aluTag;
  dataT aluData;

  logic lsEn;   // load/store unit result.
  tagT  lsTag;
  dataT lsData;

  modport src (
    output aluEn, aluTag, aluData,
    output lsEn, lsTag, lsData
  );

  // every register line listens to both buses.
  modport snoop (
    input aluEn, aluTag, aluData,
    input lsEn, lsTag, lsData
  );

endinterface

`default_nettype wire

// File: rfPkg.sv
`include "regFile_settings.svh"
`default_nettype none

package rfPkg;

  // one register value.
  typedef logic [`RF_DATA_W-1:0] dataT;

  // rename tag of the producing instruction.
  typedef logic [`RF_TAG_W-1:0] tagT;

  typedef logic [$clog2(`RF_REG_COUNT)-1:0] regNameT;   // architectural register index.
  typedef logic [$clog2(`RF_CKPT_DEPTH)-1:0] slotIdxT;  // checkpoint ring position.

  // a slot with this tag holds its final value.
  localparam tagT TAG_FREE = '0;

endpackage

`default_nettype wire

// File: regFile_settings.svh
`ifndef REGFILE_SETTINGS_SVH
`define REGFILE_SETTINGS_SVH

// number of architectural registers, r0 included.
`define RF_REG_COUNT 32

// width of one register value.
`define RF_DATA_W 32

// rename tag width, tag zero marks a final value.
`define RF_TAG_W 4

// checkpoint ring slots per register.
// the issuer keeps at most depth-1 branches in flight.
`define RF_CKPT_DEPTH 4

`endif
